//--- src/vex_pkg.sv
// vector execute stage definitions
// word widths and the enum types shared by the two-lane execute datapath

package vex_pkg;

  // lane word and address width
  localparam int XLEN = 32;
  // vector register number width
  localparam int VREG_W = 5;

  // element width, sets the signed compare size
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // operand source
  typedef enum logic [1:0] {
    SRC_V = 2'd0,
    SRC_I = 2'd1,
    SRC_X = 2'd2
  } src_type_t;

  // element alu opcodes
  typedef enum logic [2:0] {
    VALU_ADD  = 3'd0,
    VALU_AND  = 3'd1,
    VALU_OR   = 3'd2,
    VALU_XOR  = 3'd3,
    VALU_MIN  = 3'd4,
    VALU_MINU = 3'd5,
    VALU_MAX  = 3'd6,
    VALU_MAXU = 3'd7
  } valu_op_t;

  // load/store stride kind
  typedef enum logic [1:0] {
    STRIDE_UNIT    = 2'd0,
    STRIDE_CONST   = 2'd1,
    STRIDE_SEGMENT = 2'd2
  } stride_t;

  // memory element width
  typedef enum logic [1:0] {
    LSW8  = 2'd0,
    LSW16 = 2'd1,
    LSW32 = 2'd2
  } ls_width_t;

endpackage

//--- src/vex_operand_select.sv
// vector operand select
// steers the rs1 and rs2 operands of both lanes from vector, immediate or scalar data

`timescale 1ns/10ps

module vex_operand_select (
  input  logic                       CLK,
  input  logic                       nRST,
  input  vex_pkg::src_type_t         rs1_type,
  input  vex_pkg::src_type_t         rs2_type,
  input  logic [vex_pkg::XLEN-1:0]   vs1_lane0,
  input  logic [vex_pkg::XLEN-1:0]   vs1_lane1,
  input  logic [vex_pkg::XLEN-1:0]   vs2_lane0,
  input  logic [vex_pkg::XLEN-1:0]   vs2_lane1,
  input  logic [vex_pkg::XLEN-1:0]   imm,
  input  logic [vex_pkg::XLEN-1:0]   xs1,
  input  logic [vex_pkg::XLEN-1:0]   xs2,
  output logic [vex_pkg::XLEN-1:0]   op_a0,
  output logic [vex_pkg::XLEN-1:0]   op_a1,
  output logic [vex_pkg::XLEN-1:0]   op_b0,
  output logic [vex_pkg::XLEN-1:0]   op_b1
);

  // first operand, immediate and scalar broadcast to both lanes
  always_comb begin
    case (rs1_type)
      vex_pkg::SRC_V: begin
        op_a0 = vs1_lane0;
        op_a1 = vs1_lane1;
      end
      vex_pkg::SRC_I: begin
        op_a0 = imm;
        op_a1 = imm;
      end
      vex_pkg::SRC_X: begin
        op_a0 = xs1;
        op_a1 = xs1;
      end
      default: begin
        op_a0 = '0;
        op_a1 = '0;
      end
    endcase
  end

  // second operand
  always_comb begin
    case (rs2_type)
      vex_pkg::SRC_V: begin
        op_b0 = vs2_lane0;
        op_b1 = vs2_lane1;
      end
      vex_pkg::SRC_I: begin
        op_b0 = imm;
        op_b1 = imm;
      end
      vex_pkg::SRC_X: begin
        op_b0 = xs2;
        op_b1 = xs2;
      end
      default: begin
        op_b0 = '0;
        op_b1 = '0;
      end
    endcase
  end

  // decode must never hand over an unused source encoding
  a_src_type_legal: assert property (@(posedge CLK) disable iff (!nRST)
    (rs1_type inside {vex_pkg::SRC_V, vex_pkg::SRC_I, vex_pkg::SRC_X}) &&
    (rs2_type inside {vex_pkg::SRC_V, vex_pkg::SRC_I, vex_pkg::SRC_X}))
    else $error("operand source type out of range");

endmodule

//--- src/vex_lane_alu.sv
// vector lane element alu
// add, logic ops and min/max, signed compares sized by the element width

`timescale 1ns/10ps

module vex_lane_alu (
  input  logic [vex_pkg::XLEN-1:0] op_a,
  input  logic [vex_pkg::XLEN-1:0] op_b,
  input  vex_pkg::valu_op_t        aluop,
  input  vex_pkg::sew_t            sew,
  output logic [vex_pkg::XLEN-1:0] result
);

  logic lt_s;
  logic lt_u;

  // op_b below op_a, signed over the low sew bits only
  always_comb begin
    case (sew)
      vex_pkg::SEW8: begin
        lt_s = $signed(op_b[7:0]) < $signed(op_a[7:0]);
      end
      vex_pkg::SEW16: begin
        lt_s = $signed(op_b[15:0]) < $signed(op_a[15:0]);
      end
      default: begin
        lt_s = $signed(op_b) < $signed(op_a);
      end
    endcase
  end

  // unsigned compare always spans the full word
  assign lt_u = op_b < op_a;

  // min/max hand back the whole winning word, not just the element
  always_comb begin
    case (aluop)
      vex_pkg::VALU_ADD: begin
        result = op_a + op_b;
      end
      vex_pkg::VALU_AND: begin
        result = op_a & op_b;
      end
      vex_pkg::VALU_OR: begin
        result = op_a | op_b;
      end
      vex_pkg::VALU_XOR: begin
        result = op_a ^ op_b;
      end
      vex_pkg::VALU_MIN: begin
        result = lt_s ? op_b : op_a;
      end
      vex_pkg::VALU_MINU: begin
        result = lt_u ? op_b : op_a;
      end
      vex_pkg::VALU_MAX: begin
        result = lt_s ? op_a : op_b;
      end
      vex_pkg::VALU_MAXU: begin
        result = lt_u ? op_a : op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- src/vex_reduce.sv
// vector cross-lane reduction
// folds lane 0 and lane 1 into one result for reduction ops, else passes lanes through

`timescale 1ns/10ps

module vex_reduce (
  input  logic [vex_pkg::XLEN-1:0] lane0,
  input  logic [vex_pkg::XLEN-1:0] lane1,
  input  vex_pkg::valu_op_t        aluop,
  input  vex_pkg::sew_t            sew,
  input  logic                     reduction_ena,
  output logic [vex_pkg::XLEN-1:0] red0,
  output logic [vex_pkg::XLEN-1:0] red1
);

  logic [vex_pkg::XLEN-1:0] fold;

  // same element op, applied across the two lanes
  vex_lane_alu u_fold_alu (
    .op_a   (lane0),
    .op_b   (lane1),
    .aluop  (aluop),
    .sew    (sew),
    .result (fold)
  );

  // reduction result lands in slot 0
  assign red0 = reduction_ena ? fold : lane0;
  // lane 1 passes through either way
  assign red1 = lane1;

endmodule

//--- src/vex_addr_gen.sv
// vector load/store address generation
// segment base offset plus unit, constant or segment stride for both lanes

`timescale 1ns/10ps

module vex_addr_gen (
  input  logic [vex_pkg::XLEN-1:0] xs1,
  input  logic [vex_pkg::XLEN-1:0] stride_val,
  input  logic [2:0]               nf,
  input  vex_pkg::ls_width_t       ls_width,
  input  vex_pkg::stride_t         stride_type,
  output logic [vex_pkg::XLEN-1:0] addr0,
  output logic [vex_pkg::XLEN-1:0] addr1
);

  logic [1:0]               size_shift;
  logic [vex_pkg::XLEN-1:0] nf_word;
  logic [vex_pkg::XLEN-1:0] nfield_word;
  logic [vex_pkg::XLEN-1:0] base;
  logic [vex_pkg::XLEN-1:0] stride;

  // log2 of the element byte size
  always_comb begin
    case (ls_width)
      vex_pkg::LSW8: begin
        size_shift = 2'd0;
      end
      vex_pkg::LSW16: begin
        size_shift = 2'd1;
      end
      default: begin
        size_shift = 2'd2;
      end
    endcase
  end

  assign nf_word     = vex_pkg::XLEN'(nf);
  assign nfield_word = nf_word + 1'b1;

  // base skips nf fields into the segment
  assign base = xs1 + (nf_word << size_shift);

  always_comb begin
    case (stride_type)
      vex_pkg::STRIDE_CONST: begin
        stride = stride_val;
      end
      vex_pkg::STRIDE_SEGMENT: begin
        // one whole segment of nf+1 fields
        stride = nfield_word << size_shift;
      end
      default: begin
        stride = vex_pkg::XLEN'(4);
      end
    endcase
  end

  assign addr0 = base;
  assign addr1 = base + stride;

endmodule

//--- src/vex_mem_latch.sv
// execute to memory pipeline register
// flush over stall over capture, picks addresses for loads and stores

`timescale 1ns/10ps

module vex_mem_latch (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       stall,
  input  logic                       flush,
  input  logic                       load_ena,
  input  logic                       store_ena,
  input  logic [vex_pkg::XLEN-1:0]   red0,
  input  logic [vex_pkg::XLEN-1:0]   red1,
  input  logic [vex_pkg::XLEN-1:0]   addr0,
  input  logic [vex_pkg::XLEN-1:0]   addr1,
  input  logic [1:0]                 wen,
  input  logic [vex_pkg::VREG_W-1:0] vd,
  output logic                       mem_load_ena,
  output logic                       mem_store_ena,
  output logic [vex_pkg::XLEN-1:0]   mem_result0,
  output logic [vex_pkg::XLEN-1:0]   mem_result1,
  output logic [1:0]                 mem_wen,
  output logic [vex_pkg::VREG_W-1:0] mem_vd
);

  logic ls;

  // memory access carries addresses in the result slots
  assign ls = load_ena | store_ena;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      mem_load_ena  <= 1'b0;
      mem_store_ena <= 1'b0;
      mem_result0   <= '0;
      mem_result1   <= '0;
      mem_wen       <= '0;
      mem_vd        <= '0;
    end else if (flush) begin
      // flush wins even during a stall
      mem_load_ena  <= 1'b0;
      mem_store_ena <= 1'b0;
      mem_result0   <= '0;
      mem_result1   <= '0;
      mem_wen       <= '0;
      mem_vd        <= '0;
    end else if (!stall) begin
      mem_load_ena  <= load_ena;
      mem_store_ena <= store_ena;
      mem_result0   <= ls ? addr0 : red0;
      mem_result1   <= ls ? addr1 : red1;
      mem_wen       <= wen;
      mem_vd        <= vd;
    end
  end

  // decode issues either a load or a store, never both
  a_ls_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    !(load_ena && store_ena))
    else $error("load and store enabled together");

  // a stall without flush freezes the whole memory-side view
  a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> ($stable(mem_result0) && $stable(mem_result1) &&
                           $stable(mem_load_ena) && $stable(mem_store_ena) &&
                           $stable(mem_wen) && $stable(mem_vd)))
    else $error("latch outputs moved during stall");

endmodule

//--- src/vex_execute_stage.sv
// two-lane vector execute stage
// operand select, lane alus, reduction and address gen feeding the memory latch

`timescale 1ns/10ps

module vex_execute_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic [vex_pkg::XLEN-1:0]   vs1_lane0,
  input  logic [vex_pkg::XLEN-1:0]   vs1_lane1,
  input  logic [vex_pkg::XLEN-1:0]   vs2_lane0,
  input  logic [vex_pkg::XLEN-1:0]   vs2_lane1,
  input  logic [vex_pkg::XLEN-1:0]   imm,
  input  logic [vex_pkg::XLEN-1:0]   xs1,
  input  logic [vex_pkg::XLEN-1:0]   xs2,
  input  vex_pkg::src_type_t         rs1_type,
  input  vex_pkg::src_type_t         rs2_type,
  input  vex_pkg::sew_t              sew,
  input  vex_pkg::valu_op_t          aluop,
  input  logic                       reduction_ena,
  input  logic                       load_ena,
  input  logic                       store_ena,
  input  vex_pkg::stride_t           stride_type,
  input  logic [vex_pkg::XLEN-1:0]   stride_val,
  input  logic [2:0]                 nf,
  input  vex_pkg::ls_width_t         ls_width,
  input  logic [1:0]                 wen,
  input  logic [vex_pkg::VREG_W-1:0] vd,
  input  logic                       stall,
  input  logic                       flush,
  output logic                       mem_load_ena,
  output logic                       mem_store_ena,
  output logic [vex_pkg::XLEN-1:0]   mem_result0,
  output logic [vex_pkg::XLEN-1:0]   mem_result1,
  output logic [1:0]                 mem_wen,
  output logic [vex_pkg::VREG_W-1:0] mem_vd
);

  logic [vex_pkg::XLEN-1:0] op_a0, op_b0, op_a1, op_b1;
  logic [vex_pkg::XLEN-1:0] lane0_res, lane1_res;
  logic [vex_pkg::XLEN-1:0] red0, red1;
  logic [vex_pkg::XLEN-1:0] addr0, addr1;

  vex_operand_select u_opsel (
    .CLK (CLK), .nRST (nRST),
    .rs1_type (rs1_type), .rs2_type (rs2_type),
    .vs1_lane0 (vs1_lane0), .vs1_lane1 (vs1_lane1),
    .vs2_lane0 (vs2_lane0), .vs2_lane1 (vs2_lane1),
    .imm (imm), .xs1 (xs1), .xs2 (xs2),
    .op_a0 (op_a0), .op_a1 (op_a1), .op_b0 (op_b0), .op_b1 (op_b1)
  );

  vex_lane_alu u_lane0 (
    .op_a (op_a0), .op_b (op_b0), .aluop (aluop), .sew (sew), .result (lane0_res)
  );

  vex_lane_alu u_lane1 (
    .op_a (op_a1), .op_b (op_b1), .aluop (aluop), .sew (sew), .result (lane1_res)
  );

  vex_reduce u_reduce (
    .lane0 (lane0_res), .lane1 (lane1_res), .aluop (aluop), .sew (sew),
    .reduction_ena (reduction_ena), .red0 (red0), .red1 (red1)
  );

  vex_addr_gen u_addr (
    .xs1 (xs1), .stride_val (stride_val), .nf (nf), .ls_width (ls_width),
    .stride_type (stride_type), .addr0 (addr0), .addr1 (addr1)
  );

  vex_mem_latch u_latch (
    .CLK (CLK), .nRST (nRST), .stall (stall), .flush (flush),
    .load_ena (load_ena), .store_ena (store_ena),
    .red0 (red0), .red1 (red1), .addr0 (addr0), .addr1 (addr1),
    .wen (wen), .vd (vd),
    .mem_load_ena (mem_load_ena), .mem_store_ena (mem_store_ena),
    .mem_result0 (mem_result0), .mem_result1 (mem_result1),
    .mem_wen (mem_wen), .mem_vd (mem_vd)
  );

endmodule

//--- tests/tb_vex_execute.sv
// testbench for the two-lane vector execute stage
// elementwise, reduction, load/store address and stall/flush runs checked against a model

`timescale 1ns/10ps

module tb_vex_execute;

  localparam int N_ELEM = 200;
  localparam int N_RED = 80;
  localparam int N_ADDR = 80;
  localparam int N_HOLD = 3;
  localparam int STIM_CYCLES = 4 + N_ELEM + N_RED + N_ADDR + 10 * N_HOLD + 3;
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 50;

  logic CLK = 1'b0;
  logic nRST;
  logic [vex_pkg::XLEN-1:0] vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1;
  logic [vex_pkg::XLEN-1:0] imm, xs1, xs2, stride_val;
  vex_pkg::src_type_t rs1_type, rs2_type;
  vex_pkg::sew_t sew;
  vex_pkg::valu_op_t aluop;
  vex_pkg::stride_t stride_type;
  vex_pkg::ls_width_t ls_width;
  logic reduction_ena, load_ena, store_ena, stall, flush;
  logic [2:0] nf;
  logic [1:0] wen;
  logic [vex_pkg::VREG_W-1:0] vd;
  logic mem_load_ena, mem_store_ena;
  logic [vex_pkg::XLEN-1:0] mem_result0, mem_result1;
  logic [1:0] mem_wen;
  logic [vex_pkg::VREG_W-1:0] mem_vd;

  // expected latch contents
  logic exp_load = 1'b0;
  logic exp_store = 1'b0;
  logic [vex_pkg::XLEN-1:0] exp_r0 = '0;
  logic [vex_pkg::XLEN-1:0] exp_r1 = '0;
  logic [1:0] exp_wen = '0;
  logic [vex_pkg::VREG_W-1:0] exp_vd = '0;
  int cycle_count = 0;
  int unsigned seed_init;

  vex_execute_stage UUT (.*);

  always #10 CLK = ~CLK;

  // sign extension from the element width
  function automatic logic [vex_pkg::XLEN-1:0] sext(input logic [vex_pkg::XLEN-1:0] x,
                                                    input vex_pkg::sew_t s);
    case (s)
      vex_pkg::SEW8: return {{24{x[7]}}, x[7:0]};
      vex_pkg::SEW16: return {{16{x[15]}}, x[15:0]};
      default: return x;
    endcase
  endfunction

  function automatic logic [vex_pkg::XLEN-1:0] elem_op(input logic [vex_pkg::XLEN-1:0] a,
                                                       input logic [vex_pkg::XLEN-1:0] b,
                                                       input vex_pkg::valu_op_t op,
                                                       input vex_pkg::sew_t s);
    logic signed [vex_pkg::XLEN-1:0] sa;
    logic signed [vex_pkg::XLEN-1:0] sb;
    sa = sext(a, s);
    sb = sext(b, s);
    case (op)
      vex_pkg::VALU_ADD: return a + b;
      vex_pkg::VALU_AND: return a & b;
      vex_pkg::VALU_OR: return a | b;
      vex_pkg::VALU_XOR: return a ^ b;
      // on a tie min keeps a, max keeps b
      vex_pkg::VALU_MIN: return (sb < sa) ? b : a;
      vex_pkg::VALU_MAX: return (sa > sb) ? a : b;
      vex_pkg::VALU_MINU: return (b < a) ? b : a;
      default: return (a > b) ? a : b;
    endcase
  endfunction

  function automatic logic [vex_pkg::XLEN-1:0] pick_operand(input vex_pkg::src_type_t t,
                                                            input logic [vex_pkg::XLEN-1:0] vec,
                                                            input logic [vex_pkg::XLEN-1:0] scl);
    case (t)
      vex_pkg::SRC_V: return vec;
      vex_pkg::SRC_I: return imm;
      default: return scl;
    endcase
  endfunction

  // expected {result1, result0} for the inputs now on the bus
  function automatic logic [2*vex_pkg::XLEN-1:0] ref_results();
    logic [vex_pkg::XLEN-1:0] l0, l1, bytes, base, step;
    if (load_ena || store_ena) begin
      bytes = (ls_width == vex_pkg::LSW8) ? 32'd1 : (ls_width == vex_pkg::LSW16) ? 32'd2 : 32'd4;
      base = xs1 + 32'(nf) * bytes;
      case (stride_type)
        vex_pkg::STRIDE_UNIT: step = 32'd4;
        vex_pkg::STRIDE_CONST: step = stride_val;
        default: step = (32'(nf) + 32'd1) * bytes;
      endcase
      return {base + step, base};
    end
    l0 = elem_op(pick_operand(rs1_type, vs1_lane0, xs1), pick_operand(rs2_type, vs2_lane0, xs2),
                 aluop, sew);
    l1 = elem_op(pick_operand(rs1_type, vs1_lane1, xs1), pick_operand(rs2_type, vs2_lane1, xs2),
                 aluop, sew);
    if (reduction_ena) begin
      return {l1, elem_op(l0, l1, aluop, sew)};
    end
    return {l1, l0};
  endfunction

  // reference latch, flush over stall over capture
  always @(posedge CLK or negedge nRST) begin
    if (!nRST || flush) begin
      {exp_load, exp_store, exp_r0, exp_r1, exp_wen, exp_vd} <= '0;
    end else if (!stall) begin
      {exp_r1, exp_r0} <= ref_results();
      exp_load <= load_ena;
      exp_store <= store_ena;
      exp_wen <= wen;
      exp_vd <= vd;
    end
  end

  task automatic check_word(input string name, input logic [vex_pkg::XLEN-1:0] exp,
                            input logic [vex_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_ctrl(input string name, input logic [vex_pkg::VREG_W-1:0] exp,
                            input logic [vex_pkg::VREG_W-1:0] act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "control mismatch");
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge CLK) begin
    check_ctrl("mem_load_ena", vex_pkg::VREG_W'(exp_load), vex_pkg::VREG_W'(mem_load_ena));
    check_ctrl("mem_store_ena", vex_pkg::VREG_W'(exp_store), vex_pkg::VREG_W'(mem_store_ena));
    check_ctrl("mem_wen", vex_pkg::VREG_W'(exp_wen), vex_pkg::VREG_W'(mem_wen));
    check_ctrl("mem_vd", exp_vd, mem_vd);
    check_word("mem_result0", exp_r0, mem_result0);
    check_word("mem_result1", exp_r1, mem_result1);
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, stimulus still running after %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic random_data();
    vs1_lane0 = $urandom;
    vs1_lane1 = $urandom;
    vs2_lane0 = $urandom;
    vs2_lane1 = $urandom;
    imm = $urandom;
    xs1 = $urandom;
    xs2 = $urandom;
    stride_val = $urandom;
    wen = 2'($urandom);
    vd = vex_pkg::VREG_W'($urandom);
  endtask

  task automatic random_elem();
    random_data();
    aluop = vex_pkg::valu_op_t'(3'($urandom));
    rs1_type = vex_pkg::src_type_t'(2'($urandom_range(2)));
    rs2_type = vex_pkg::src_type_t'(2'($urandom_range(2)));
    sew = vex_pkg::sew_t'(2'($urandom_range(2)));
    reduction_ena = 1'($urandom);
  endtask

  initial begin
    seed_init = $urandom(32'hb4df);
    nRST = 1'b0;
    {vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, imm, xs1, xs2, stride_val} = '0;
    rs1_type = vex_pkg::SRC_V;
    rs2_type = vex_pkg::SRC_V;
    sew = vex_pkg::SEW8;
    aluop = vex_pkg::VALU_ADD;
    stride_type = vex_pkg::STRIDE_UNIT;
    ls_width = vex_pkg::LSW8;
    {reduction_ena, load_ena, store_ena, stall, flush, nf, wen, vd} = '0;
    repeat (4) @(posedge CLK);
    #2 nRST = 1'b1;

    // every opcode against every source pairing, three element widths
    for (int i = 0; i < N_ELEM; i++) begin
      next_cycle();
      random_data();
      aluop = vex_pkg::valu_op_t'(3'(i % 8));
      rs1_type = vex_pkg::src_type_t'(2'((i / 8) % 3));
      rs2_type = vex_pkg::src_type_t'(2'((i / 24) % 3));
      sew = vex_pkg::sew_t'(2'(i % 3));
    end

    // odd steps pit lanes with opposite upper halves in signed min/max
    reduction_ena = 1'b1;
    for (int i = 0; i < N_RED; i++) begin
      next_cycle();
      random_elem();
      reduction_ena = 1'b1;
      if (i % 2 == 1) begin
        rs1_type = vex_pkg::SRC_V;
        rs2_type = vex_pkg::SRC_V;
        vs1_lane1 = {~vs1_lane0[31:16], vs1_lane1[15:0]};
        vs2_lane0 = vs1_lane0;
        vs2_lane1 = vs1_lane1;
        aluop = (i % 4 == 1) ? vex_pkg::VALU_MIN : vex_pkg::VALU_MAX;
        sew = (i % 8 < 4) ? vex_pkg::SEW8 : vex_pkg::SEW16;
      end
    end

    for (int i = 0; i < N_ADDR; i++) begin
      next_cycle();
      random_elem();
      load_ena = (i % 2 == 0);
      store_ena = (i % 2 != 0);
      stride_type = vex_pkg::stride_t'(2'(i % 3));
      ls_width = vex_pkg::ls_width_t'(2'((i / 3) % 3));
      nf = 3'(i % 8);
    end
    load_ena = 1'b0;
    store_ena = 1'b0;

    // stalled instruction stays on the bus until the stall drops
    for (int k = 0; k < N_HOLD; k++) begin
      next_cycle();
      random_elem();
      next_cycle();
      random_elem();
      stall = 1'b1;
      repeat (3) next_cycle();
      next_cycle();
      stall = 1'b0;
      next_cycle();
      random_elem();
      flush = 1'b1;
      next_cycle();
      flush = 1'b0;
      next_cycle();
      random_elem();
      stall = 1'b1;
      flush = 1'b1;
      next_cycle();
      stall = 1'b0;
      flush = 1'b0;
    end

    repeat (2) next_cycle();
    @(negedge CLK);
    #1;
    $display("** PASS **");
    $finish;
  end

endmodule

//--- compile.f
src/vex_pkg.sv
src/vex_operand_select.sv
src/vex_lane_alu.sv
src/vex_reduce.sv
src/vex_addr_gen.sv
src/vex_mem_latch.sv
src/vex_execute_stage.sv
tests/tb_vex_execute.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vector execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_vex_execute \
    -f compile.f -o vex_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vex_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q '\*\* PASS \*\*' "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed (exit status $sim_status)"
exit 1
